//--- gicDma.f
+incdir+.
gicPkg.sv
gicCfgQueue.sv
gicXferCtrl.sv
glbBank.sv
gicItfPort.sv
gicTop.sv
gicTb.sv

//--- gicTbTasks.svh
// Compare tasks and GLB model helpers, included inside the gicTb module body
// Relies on the testbench's model arrays and on failNow
`ifndef GIC_TB_TASKS_SVH
`define GIC_TB_TASKS_SVH

    // ======================================
    // Model helpers
    // ======================================
    // GLB index wraps at GlbDepth like the low address bits
    function automatic int glbIdx(input logic [glbAddrW-1:0] base, input int i);
        return (int'(base) + i) % GlbDepth;
    endfunction

    // Expected header, padding zero
    function automatic gicHdrT makeHdr(input gicCfgT c);
        gicHdrT h;
        h          = '0;
        h.num      = c.num;
        h.dramBase = c.dramBase;
        h.dir      = c.dir;
        return h;
    endfunction

    // Words of a finished inbound transfer into the model GLB
    task automatic applyInWrites(input int x);
        for (int i = 0; i < inCount[x]; i++) begin
            modelMem[glbIdx(cfgArr[x].glbBase, i)] = inData[inStart[x] + i];
        end
    endtask

    // ======================================
    // Compare tasks
    // ======================================
    task automatic checkHdr(input gicHdrT got, input gicHdrT exp, input int x);
        if (got !== exp) begin
            failNow($sformatf("ERROR at %0t: xfer %0d hdr num=%0d dram=%h dir=%0b pad=%0h, %s",
                              $time, x, got.num, got.dramBase, got.dir, got.pad,
                              $sformatf("expected num=%0d dram=%h dir=%0b",
                                        exp.num, exp.dramBase, exp.dir)));
        end
    endtask

    task automatic checkData(input logic [portW-1:0] got, input logic gotLast,
                             input logic [portW-1:0] exp, input logic expLast,
                             input int x, input int i);
        if (got !== exp || gotLast !== expLast) begin
            failNow($sformatf("ERROR at %0t: xfer %0d word %0d = %h last %0b, expected %h last %0b",
                              $time, x, i, got, gotLast, exp, expLast));
        end
    endtask

    // Counters and single flags
    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            failNow($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

`endif

//--- gicTb.sv
// Testbench for gicTop, random configs and off-chip traffic from a fixed seed
// The GLB is filled by inbound transfers before any outbound read
`timescale 1ns/1ps
`default_nettype none

module gicTb
    import gicPkg::*;
();

    localparam int CfgDepth    = 4;
    localparam int GlbDepth    = 256;
    localparam int OutCredits  = 4;
    localparam int InDepth     = 4;
    localparam int ClkPeriod   = 100;
    localparam int MaxNum      = 16;
    localparam int NumFill     = GlbDepth / MaxNum;
    localparam int NumXfer     = NumFill + 40;
    localparam int MaxWords    = NumXfer * MaxNum;
    localparam int DrainCycles = 20;
    // 40 words of 10 cycles for each transfer
    localparam int WatchdogNs  = NumXfer * 40 * 10 * ClkPeriod;

    // ======================================
    // DUT signals
    // ======================================
    logic             clk;
    logic             rst_n;
    logic             cfgVld;
    gicCfgT           cfgInfo;
    logic             cfgCredit;
    outBeatT          outBeat;
    logic             itfCredit;
    logic             inVld;
    logic [portW-1:0] inDat;
    logic             inLast;
    logic             inCredit;
    logic             xferDone;

    // Stimulus, built once before reset
    integer           seed;
    gicCfgT           cfgArr [NumXfer];
    int               inStart [NumXfer];
    int               inCount [NumXfer];
    logic [portW-1:0] inData [MaxWords];
    logic             inLastArr [MaxWords];
    int               inTotal;

    // Model state
    logic [portW-1:0] modelMem [GlbDepth];
    int               cfgCred;
    int               inCred;
    int               outCred;
    int               heldSlots;
    int               pushIdx;
    int               sendIdx;
    int               cfgCreditCnt;
    int               inCreditCnt;
    int               doneCnt;
    int               curX;
    logic             hdrSeen;
    int               dataSeen;
    logic             doneSeen;

    gicTop #(
        .CfgDepth   (CfgDepth),
        .GlbDepth   (GlbDepth),
        .OutCredits (OutCredits),
        .InDepth    (InDepth)
    ) i_gicTop (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfgVld    (cfgVld),
        .cfgInfo   (cfgInfo),
        .cfgCredit (cfgCredit),
        .outBeat   (outBeat),
        .itfCredit (itfCredit),
        .inVld     (inVld),
        .inDat     (inDat),
        .inLast    (inLast),
        .inCredit  (inCredit),
        .xferDone  (xferDone)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    // Report and stop at the first error
    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    `include "gicTbTasks.svh"

    // ======================================
    // Random helpers
    // ======================================
    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [portW-1:0] randWord();
        logic [portW-1:0] w;
        for (int k = 0; k < portW / 32; k++) begin
            w[k*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    // Fill transfers first, then random ones
    task automatic buildStimulus();
        gicCfgT c;
        int     words;
        inTotal = 0;
        for (int x = 0; x < NumXfer; x++) begin
            if (x < NumFill) begin
                c.glbBase = glbAddrW'(x * MaxNum);
                c.num     = glbAddrW'(MaxNum);
                c.dir     = dirIn2Chip;
            end else begin
                c.glbBase = glbAddrW'(randBelow(GlbDepth));
                c.num     = glbAddrW'(1 + randBelow(MaxNum));
                c.dir     = (randBelow(2) == 1) ? dirOut2Off : dirIn2Chip;
            end
            c.dramBase = $random(seed);
            words      = int'(c.num);
            // Some inbound transfers end early on inLast
            if (x >= NumFill && c.dir == dirIn2Chip && randBelow(4) == 0) begin
                words = 1 + randBelow(int'(c.num));
            end
            cfgArr[x]  = c;
            inStart[x] = inTotal;
            inCount[x] = (c.dir == dirIn2Chip) ? words : 0;
            for (int i = 0; i < inCount[x]; i++) begin
                inData[inTotal]    = randWord();
                inLastArr[inTotal] = (words < int'(c.num)) && (i == words - 1);
                inTotal++;
            end
        end
    endtask

    // ======================================
    // Per-cycle monitor and driver
    // ======================================
    task automatic nextXfer();
        curX++;
        hdrSeen  = 1'b0;
        dataSeen = 0;
        doneSeen = 1'b0;
    endtask

    // First beat is the header, then num data beats for OUT2OFF
    task automatic takeBeat();
        gicCfgT c;
        c = cfgArr[curX];
        if (curX >= NumXfer) begin
            failNow("Outbound beat seen after the last transfer had finished");
        end else if (!hdrSeen) begin
            checkHdr(outBeat.beat.hdr, makeHdr(c), curX);
            // Header beat never carries last
            checkCount("last flag on a header beat", int'(outBeat.last !== 1'b0), 0);
            hdrSeen = 1'b1;
        end else if (c.dir == dirOut2Off && dataSeen < int'(c.num)) begin
            checkData(outBeat.beat.raw, outBeat.last, modelMem[glbIdx(c.glbBase, dataSeen)],
                      dataSeen == int'(c.num) - 1, curX, dataSeen);
            dataSeen++;
            if (dataSeen == int'(c.num)) begin
                // Done pulses with the last read, a cycle ahead of its beat
                checkCount("xferDone before the last outbound beat", int'(doneSeen), 1);
                nextXfer();
            end
        end else begin
            failNow($sformatf("Extra outbound beat in transfer %0d", curX));
        end
    endtask

    task automatic takeDone();
        gicCfgT c;
        c = cfgArr[curX];
        if (curX >= NumXfer || !hdrSeen || doneSeen) begin
            failNow($sformatf("Stray xferDone pulse at %0t with no transfer open", $time));
        end else begin
            doneSeen = 1'b1;
            doneCnt++;
            if (c.dir == dirIn2Chip) begin
                applyInWrites(curX);
                nextXfer();
            end else begin
                checkCount("outbound beats before xferDone", dataSeen, int'(c.num) - 1);
            end
        end
    endtask

    task automatic monitorCycle();
        if (cfgCredit) begin
            cfgCreditCnt++;
            cfgCred++;
            if (cfgCred > CfgDepth) begin
                failNow("cfgCredit returned more credits than configs were pushed");
            end
        end
        if (inCredit) begin
            inCreditCnt++;
            inCred++;
            if (inCred > InDepth) begin
                failNow("inCredit returned more credits than beats were sent");
            end
        end
        if (outBeat.vld) begin
            if (outCred == 0) begin
                failNow("Outbound beat sent while the off-chip side had no free slot");
            end
            outCred--;
            heldSlots++;
            takeBeat();
        end
        if (xferDone) begin
            takeDone();
        end
    endtask

    task automatic driveCycle();
        cfgVld    = 1'b0;
        inVld     = 1'b0;
        inLast    = 1'b0;
        itfCredit = 1'b0;
        // Control unit pushes at random while it holds a credit
        if (pushIdx < NumXfer && cfgCred > 0 && randBelow(3) != 0) begin
            cfgVld  = 1'b1;
            cfgInfo = cfgArr[pushIdx];
            pushIdx++;
            cfgCred--;
        end
        if (sendIdx < inTotal && inCred > 0 && randBelow(4) != 0) begin
            inVld  = 1'b1;
            inDat  = inData[sendIdx];
            inLast = inLastArr[sendIdx];
            sendIdx++;
            inCred--;
        end
        // Off-chip side frees a slot after a random delay
        if (heldSlots > 0 && randBelow(3) == 0) begin
            itfCredit = 1'b1;
            heldSlots--;
            outCred++;
        end
    endtask

    task automatic checkQuiet();
        checkCount("outBeat.vld before the first config", int'(outBeat.vld !== 1'b0), 0);
        checkCount("cfgCredit before the first config", int'(cfgCredit !== 1'b0), 0);
        checkCount("inCredit before the first config", int'(inCredit !== 1'b0), 0);
        checkCount("xferDone before the first config", int'(xferDone !== 1'b0), 0);
    endtask

    // ======================================
    // Main sequence
    // ======================================
    initial begin
        seed         = 43;
        rst_n        = 1'b0;
        cfgVld       = 1'b0;
        cfgInfo      = '0;
        itfCredit    = 1'b0;
        inVld        = 1'b0;
        inDat        = '0;
        inLast       = 1'b0;
        cfgCred      = CfgDepth;
        inCred       = InDepth;
        outCred      = OutCredits;
        heldSlots    = 0;
        pushIdx      = 0;
        sendIdx      = 0;
        cfgCreditCnt = 0;
        inCreditCnt  = 0;
        doneCnt      = 0;
        curX         = 0;
        hdrSeen      = 1'b0;
        dataSeen     = 0;
        doneSeen     = 1'b0;
        buildStimulus();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Nothing pushed yet
        repeat (3) begin
            @(negedge clk);
            checkQuiet();
        end
        while (curX < NumXfer) begin
            @(negedge clk);
            monitorCycle();
            driveCycle();
        end
        // Late credit pulses, no further beats
        repeat (DrainCycles) begin
            @(negedge clk);
            monitorCycle();
            driveCycle();
        end
        checkCount("xferDone pulses", doneCnt, NumXfer);
        checkCount("cfgCredit pulses", cfgCreditCnt, NumXfer);
        checkCount("inbound beats sent", sendIdx, inTotal);
        checkCount("inCredit pulses", inCreditCnt, inTotal);
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        failNow("Watchdog timeout, the transfers did not all finish in time");
    end

endmodule

`default_nettype wire

//--- gicTop.sv
// Global input controller top, config queue, FSM, GLB and off-chip port
// Credit counts after reset are CfgDepth, OutCredits and InDepth
`timescale 1ns/1ps
`default_nettype none

module gicTop
    import gicPkg::*;
#(
    parameter int CfgDepth   = 4,
    parameter int GlbDepth   = 256,
    parameter int OutCredits = 4,
    parameter int InDepth    = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    // Control unit
    input  logic             cfgVld,
    input  gicCfgT           cfgInfo,
    output logic             cfgCredit,
    // Off-chip outbound
    output outBeatT          outBeat,
    input  logic             itfCredit,
    // Off-chip inbound
    input  logic             inVld,
    input  logic [portW-1:0] inDat,
    input  logic             inLast,
    output logic             inCredit,
    output logic             xferDone
);

    // ======================================
    // Internal links
    // ======================================
    logic                headVld;
    gicCfgT              head;
    logic                headPop;
    logic                hdrReq;
    gicHdrT              hdr;
    logic                hdrTaken;
    logic                outRoom;
    logic                rdIssue;
    logic                rdLast;
    logic [glbAddrW-1:0] rdAddr;
    logic [portW-1:0]    rdDat;
    glbWrT               glbWr;
    logic                inHeadVld;
    logic [portW-1:0]    inHeadDat;
    logic                inHeadLast;
    logic                inPop;

    // Input side
    gicCfgQueue #(
        .CfgDepth (CfgDepth)
    ) i_cfgQueue (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfgVld    (cfgVld),
        .cfgInfo   (cfgInfo),
        .cfgCredit (cfgCredit),
        .headVld   (headVld),
        .head      (head),
        .headPop   (headPop)
    );

    // Processing
    gicXferCtrl i_xferCtrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .headVld    (headVld),
        .head       (head),
        .headPop    (headPop),
        .hdrReq     (hdrReq),
        .hdr        (hdr),
        .hdrTaken   (hdrTaken),
        .outRoom    (outRoom),
        .rdIssue    (rdIssue),
        .rdLast     (rdLast),
        .rdAddr     (rdAddr),
        .glbWr      (glbWr),
        .inHeadVld  (inHeadVld),
        .inHeadDat  (inHeadDat),
        .inHeadLast (inHeadLast),
        .inPop      (inPop),
        .xferDone   (xferDone)
    );

    glbBank #(
        .GlbDepth (GlbDepth)
    ) i_glbBank (
        .clk    (clk),
        .glbWr  (glbWr),
        .rdEn   (rdIssue),
        .rdAddr (rdAddr),
        .rdDat  (rdDat)
    );

    // Output side
    gicItfPort #(
        .OutCredits (OutCredits),
        .InDepth    (InDepth)
    ) i_itfPort (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdrReq     (hdrReq),
        .hdr        (hdr),
        .hdrTaken   (hdrTaken),
        .outRoom    (outRoom),
        .rdIssue    (rdIssue),
        .rdLast     (rdLast),
        .rdDat      (rdDat),
        .outBeat    (outBeat),
        .itfCredit  (itfCredit),
        .inVld      (inVld),
        .inDat      (inDat),
        .inLast     (inLast),
        .inCredit   (inCredit),
        .inHeadVld  (inHeadVld),
        .inHeadDat  (inHeadDat),
        .inHeadLast (inHeadLast),
        .inPop      (inPop)
    );

endmodule

`default_nettype wire

//--- gicItfPort.sv
// Off-chip port, credit based on both links
// Off-chip side sends inbound beats only while it holds a credit
`timescale 1ns/1ps
`default_nettype none

module gicItfPort
    import gicPkg::*;
#(
    parameter int OutCredits = 4,
    parameter int InDepth    = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    // Header from the controller
    input  logic             hdrReq,
    input  gicHdrT           hdr,
    output logic             hdrTaken,
    // Outbound reads
    output logic             outRoom,
    input  logic             rdIssue,
    input  logic             rdLast,
    input  logic [portW-1:0] rdDat,
    // Outbound link
    output outBeatT          outBeat,
    input  logic             itfCredit,
    // Inbound link
    input  logic             inVld,
    input  logic [portW-1:0] inDat,
    input  logic             inLast,
    output logic             inCredit,
    // Inbound FIFO head to the controller
    output logic             inHeadVld,
    output logic [portW-1:0] inHeadDat,
    output logic             inHeadLast,
    input  logic             inPop
);

    localparam int CredW  = $clog2(OutCredits + 1);
    localparam int InPtrW = (InDepth > 1) ? $clog2(InDepth) : 1;
    localparam int InCntW = $clog2(InDepth + 1);

    // ======================================
    // Outbound credits and beat mux
    // ======================================
    logic [CredW-1:0] credCnt;
    logic             rdPend;
    logic             lastDly;

    // Header and reads never share a cycle, one credit each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credCnt <= CredW'(OutCredits);
        end else begin
            credCnt <= credCnt + CredW'(itfCredit) - CredW'(hdrTaken || rdIssue);
        end
    end

    assign outRoom  = (credCnt != '0);
    assign hdrTaken = hdrReq && outRoom;

    // Read data lands one cycle after rdIssue, last follows it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPend  <= 1'b0;
            lastDly <= 1'b0;
        end else begin
            rdPend  <= rdIssue;
            lastDly <= rdLast;
        end
    end

    always_comb begin
        outBeat.beat.raw = rdDat;
        if (hdrTaken) begin
            outBeat.beat.hdr = hdr;
        end
        outBeat.last = rdPend && lastDly;
        outBeat.vld  = hdrTaken || rdPend;
    end

    // ======================================
    // Inbound FIFO
    // ======================================
    logic [portW-1:0]   inDatMem [InDepth];
    logic [InDepth-1:0] inLastMem;
    logic [InPtrW-1:0]  inWrPtr;
    logic [InPtrW-1:0]  inRdPtr;
    logic [InCntW-1:0]  inCnt;

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (inVld) begin
            inDatMem[inWrPtr]  <= inDat;
            inLastMem[inWrPtr] <= inLast;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inWrPtr  <= '0;
            inRdPtr  <= '0;
            inCnt    <= '0;
            inCredit <= 1'b0;
        end else begin
            if (inVld) begin
                inWrPtr <= (inWrPtr == InPtrW'(InDepth - 1)) ? '0 : inWrPtr + 1'b1;
            end
            if (inPop) begin
                inRdPtr <= (inRdPtr == InPtrW'(InDepth - 1)) ? '0 : inRdPtr + 1'b1;
            end
            inCnt    <= inCnt + InCntW'(inVld) - InCntW'(inPop);
            // Freed slot goes back to the off-chip side
            inCredit <= inPop;
        end
    end

    assign inHeadVld  = (inCnt != '0);
    assign inHeadDat  = inDatMem[inRdPtr];
    assign inHeadLast = inLastMem[inRdPtr];

endmodule

`default_nettype wire

//--- glbBank.sv
// Global buffer, single-clock RAM with one write and one read port
// Addresses wrap modulo GlbDepth, GlbDepth should be a power of two
`timescale 1ns/1ps
`default_nettype none

module glbBank
    import gicPkg::*;
#(
    parameter int GlbDepth = 256
) (
    input  logic                clk,
    // Write port from the controller
    input  glbWrT               glbWr,
    // Read port, data one cycle after rdEn
    input  logic                rdEn,
    input  logic [glbAddrW-1:0] rdAddr,
    output logic [portW-1:0]    rdDat
);

    localparam int IdxW = (GlbDepth > 1) ? $clog2(GlbDepth) : 1;

    // ======================================
    // Storage
    // ======================================
    logic [portW-1:0] mem [GlbDepth];
    logic [IdxW-1:0]  wrIdx;
    logic [IdxW-1:0]  rdIdx;

    // Low address bits index the array
    assign wrIdx = glbWr.addr[IdxW-1:0];
    assign rdIdx = rdAddr[IdxW-1:0];

    // Write takes effect at this edge
    always_ff @(posedge clk) begin
        if (glbWr.vld) begin
            mem[wrIdx] <= glbWr.data;
        end
    end

    // Registered read
    // Output holds its last value while rdEn is low
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdDat <= mem[rdIdx];
        end
    end

endmodule

`default_nettype wire

//--- gicXferCtrl.sv
// Transfer FSM, one config at a time, taken from the queue head in IDLE
// Inbound beats beyond num without inLast stay queued for the next transfer
`timescale 1ns/1ps
`default_nettype none

module gicXferCtrl
    import gicPkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // Config queue
    input  logic                headVld,
    input  gicCfgT              head,
    output logic                headPop,
    // Header request to the port
    output logic                hdrReq,
    output gicHdrT              hdr,
    input  logic                hdrTaken,
    // Outbound reads
    input  logic                outRoom,
    output logic                rdIssue,
    output logic                rdLast,
    output logic [glbAddrW-1:0] rdAddr,
    // Inbound writes
    output glbWrT               glbWr,
    input  logic                inHeadVld,
    input  logic [portW-1:0]    inHeadDat,
    input  logic                inHeadLast,
    output logic                inPop,
    output logic                xferDone
);

    // ======================================
    // State encoding
    // ======================================
    localparam logic [1:0] StIdle    = 2'd0;
    localparam logic [1:0] StCmd     = 2'd1;
    localparam logic [1:0] StIn2Chip = 2'd2;
    localparam logic [1:0] StOut2Off = 2'd3;

    logic [1:0]          state;
    gicCfgT              cfgR;
    logic [glbAddrW-1:0] cnt;
    logic [glbAddrW-1:0] wordAddr;
    logic                lastCnt;
    logic                wrLast;
    logic                emptyDone;

    // Latched config, loaded on pop
    always_ff @(posedge clk) begin
        if (headPop) begin
            cfgR <= head;
        end
    end

    // ======================================
    // Word counter and address
    // ======================================
    // Counts issued reads or popped writes, cleared while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (state == StIdle) begin
            cnt <= '0;
        end else if (rdIssue || inPop) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign wordAddr = cfgR.glbBase + cnt;
    assign lastCnt  = (cnt == cfgR.num - 1'b1);

    // ======================================
    // Handshakes
    // ======================================
    // Pop straight from IDLE, header request from the next cycle
    assign headPop = (state == StIdle) && headVld;
    assign hdrReq  = (state == StCmd);

    // Header fields straight from the latched config
    always_comb begin
        hdr          = '0;
        hdr.num      = cfgR.num;
        hdr.dramBase = cfgR.dramBase;
        hdr.dir      = cfgR.dir;
    end

    // One read per cycle while the port has a credit
    assign rdIssue = (state == StOut2Off) && outRoom;
    assign rdLast  = rdIssue && lastCnt;
    assign rdAddr  = wordAddr;

    // Inbound head goes straight into the GLB
    assign inPop      = (state == StIn2Chip) && inHeadVld;
    assign glbWr.addr = wordAddr;
    assign glbWr.data = inHeadDat;
    assign glbWr.vld  = inPop;

    // Early end on inLast
    assign wrLast = inPop && (lastCnt || inHeadLast);

    // Zero-length config ends right after its header
    assign emptyDone = hdrReq && hdrTaken && (cfgR.num == '0);

    assign xferDone = rdLast || wrLast || emptyDone;

    // ======================================
    // FSM
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle: begin
                    if (headVld) begin
                        state <= StCmd;
                    end
                end
                StCmd: begin
                    if (hdrTaken) begin
                        if (cfgR.num == '0) begin
                            state <= StIdle;
                        end else if (cfgR.dir == dirOut2Off) begin
                            state <= StOut2Off;
                        end else begin
                            state <= StIn2Chip;
                        end
                    end
                end
                StIn2Chip: begin
                    if (wrLast) begin
                        state <= StIdle;
                    end
                end
                StOut2Off: begin
                    if (rdLast) begin
                        state <= StIdle;
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- gicCfgQueue.sv
// Config queue, the control unit pushes only while it holds a credit
// No full check on push, credits keep the queue from overflowing
`timescale 1ns/1ps
`default_nettype none

module gicCfgQueue
    import gicPkg::*;
#(
    parameter int CfgDepth = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    // Control unit side
    input  logic   cfgVld,
    input  gicCfgT cfgInfo,
    output logic   cfgCredit,
    // Controller side
    output logic   headVld,
    output gicCfgT head,
    input  logic   headPop
);

    localparam int PtrW = (CfgDepth > 1) ? $clog2(CfgDepth) : 1;
    localparam int CntW = $clog2(CfgDepth + 1);

    // ======================================
    // Storage and pointers
    // ======================================
    gicCfgT          mem [CfgDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    // Entry payload, no reset
    always_ff @(posedge clk) begin
        if (cfgVld) begin
            mem[wrPtr] <= cfgInfo;
        end
    end

    // Pointers wrap at CfgDepth, depth need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (cfgVld) begin
                wrPtr <= (wrPtr == PtrW'(CfgDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (headPop) begin
                rdPtr <= (rdPtr == PtrW'(CfgDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + CntW'(cfgVld) - CntW'(headPop);
        end
    end

    // ======================================
    // Head and credit return
    // ======================================
    assign headVld = (count != '0);
    assign head    = mem[rdPtr];

    // One credit per popped entry, a cycle after the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfgCredit <= 1'b0;
        end else begin
            cfgCredit <= headPop;
        end
    end

endmodule

`default_nettype wire

//--- gicPkg.sv
// Shared widths and types for the global input controller
// GLB word and port width are the same, so one beat carries one GLB word
`default_nettype none

package gicPkg;

    // ======================================
    // Widths
    // ======================================
    localparam int portW     = 128;
    localparam int dramAddrW = 32;
    localparam int glbAddrW  = 16;

    // Header padding above num, dramBase and dir
    localparam int hdrPadW = portW - glbAddrW - dramAddrW - 1;

    // ======================================
    // Config instruction
    // ======================================
    typedef enum logic {
        dirIn2Chip = 1'b0,
        dirOut2Off = 1'b1
    } gicDirE;

    // 65 bits, glbBase in the top bits
    typedef struct packed {
        logic [glbAddrW-1:0]  glbBase;
        logic [dramAddrW-1:0] dramBase;
        logic [glbAddrW-1:0]  num;
        gicDirE               dir;
    } gicCfgT;

    // ======================================
    // Off-chip beats
    // ======================================
    // Command header, zero padded at the top
    typedef struct packed {
        logic [hdrPadW-1:0]   pad;
        logic [glbAddrW-1:0]  num;
        logic [dramAddrW-1:0] dramBase;
        logic                 dir;
    } gicHdrT;

    // First beat of a transfer reads as hdr, later beats as raw data
    typedef union packed {
        gicHdrT           hdr;
        logic [portW-1:0] raw;
    } itfBeatU;

    typedef struct packed {
        itfBeatU beat;
        logic    last;
        logic    vld;
    } outBeatT;

    // GLB write request from the controller
    typedef struct packed {
        logic [glbAddrW-1:0] addr;
        logic [portW-1:0]    data;
        logic                vld;
    } glbWrT;

endpackage

`default_nettype wire
